/* vlog.f */
eq_pkg.sv
eq_sign_corr.sv
eq_coe_adapt.sv
eq_fir.sv
lms_equalizer_top.sv
tb_lms_equalizer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the equalizer testbench with Verilator

set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f \
    --top-module tb_lms_equalizer \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
    echo "No pass line found in $LOG"
    exit 1
fi
exit 0

/* tb_lms_equalizer.sv */
`timescale 1ns/1ps

module tb_lms_equalizer;

    localparam int DW    = eq_pkg::DEF_DATA_W;
    localparam int CW    = eq_pkg::DEF_COE_W;
    localparam int IW    = eq_pkg::DEF_INV_W;
    localparam int N     = eq_pkg::DEF_COE_NUM;
    localparam int SD    = eq_pkg::DEF_SYM_DLY;
    localparam int FW    = CW + IW;
    localparam int OW    = DW + CW + 5;
    localparam int CTR   = N / 2;
    localparam int PW    = eq_pkg::NORM_PERIOD_W;
    // Stimulus takes about 2500 cycles
    localparam int LIMIT = 20000;

    // Top CW bits of the unit value 2^(FW-3)-1
    localparam int UNIT_TOP = ((1 << (FW - 3)) - 1) >>> IW;

    logic                    clk;
    logic                    sreset_eq;
    logic signed [DW-1:0]    i_dtin_i;
    logic signed [DW-1:0]    i_dtin_q;
    logic                    i_vldin;
    logic                    i_err_i;
    logic                    i_err_q;
    logic                    i_sym_vld;
    logic                    i_preset;
    logic                    i_load;
    logic                    i_teach_en;
    logic [PW-1:0]           i_norm_period;
    logic signed [FW-1:0]    i_coedata;
    logic signed [OW-1:0]    o_dout_ii;
    logic signed [OW-1:0]    o_dout_qq;
    logic signed [OW-1:0]    o_dout_iq;
    logic signed [OW-1:0]    o_dout_qi;
    logic                    o_vld;

    int          errors = 0;
    int          cycles = 0;
    logic [31:0] seed = 32'd17;

    // Reference model state
    logic                    rst_m;
    logic                    m_preset;
    logic                    m_load;
    logic                    m_teach;
    logic [PW-1:0]           m_period;
    logic [PW-1:0]           m_cnt;
    logic                    m_norm;
    logic signed [FW-1:0]    m_chain [N];
    logic signed [FW-1:0]    m_acc_i [N];
    logic signed [FW-1:0]    m_acc_q [N];
    logic signed [CW-1:0]    m_rnd_i [N];
    logic signed [CW-1:0]    m_rnd_q [N];
    logic signed [CW-1:0]    m_coe_i [N];
    logic signed [CW-1:0]    m_coe_q [N];
    logic [1:0]              m_dly [SD];
    logic [1:0]              m_sgn [N];
    logic                    m_corr_i [N];
    logic                    m_corr_q [N];
    logic signed [DW-1:0]    m_line_i [N];
    logic signed [DW-1:0]    m_line_q [N];
    // Expected outputs in the order II QQ IQ QI
    logic signed [OW-1:0]    exp_now [4];
    logic signed [OW-1:0]    exp_d1 [4];
    logic signed [OW-1:0]    exp_d2 [4];
    logic                    vld_d1;
    logic                    vld_d2;

    lms_equalizer_top DUT (
        .clk           (clk),
        .sreset_eq     (sreset_eq),
        .i_dtin_i      (i_dtin_i),
        .i_dtin_q      (i_dtin_q),
        .i_vldin       (i_vldin),
        .i_err_i       (i_err_i),
        .i_err_q       (i_err_q),
        .i_sym_vld     (i_sym_vld),
        .i_preset      (i_preset),
        .i_load        (i_load),
        .i_teach_en    (i_teach_en),
        .i_norm_period (i_norm_period),
        .i_coedata     (i_coedata),
        .o_dout_ii     (o_dout_ii),
        .o_dout_qq     (o_dout_qq),
        .o_dout_iq     (o_dout_iq),
        .o_dout_qi     (o_dout_qi),
        .o_vld         (o_vld)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    // Round half up to CW bits with positive saturation
    function automatic logic signed [CW-1:0] round_coe(input logic signed [FW-1:0] acc);
        int v;
        v = (int'(acc) + (1 << (IW - 1))) >>> IW;
        if (v > (1 << (CW - 1)) - 1) begin
            v = (1 << (CW - 1)) - 1;
        end
        return CW'(v);
    endfunction

    function automatic logic signed [FW-1:0] adapt(
        input logic signed [FW-1:0] acc,
        input logic                 corr,
        input logic                 leak
    );
        if (leak) begin
            return (acc < 0) ? acc + 1 : acc - 1;
        end
        return corr ? acc - 1 : acc + 1;
    endfunction

    assign m_norm = i_sym_vld && (m_cnt == m_period);

    always @(posedge clk) begin
        rst_m <= sreset_eq;
        if (rst_m) begin
            {m_preset, m_load, m_teach} <= 3'b100;
            m_period <= eq_pkg::NORM_PERIOD_RST;
        end else begin
            {m_preset, m_load, m_teach} <= {i_preset, i_load, i_teach_en};
            m_period <= i_norm_period;
        end
        if (rst_m || m_norm) begin
            m_cnt <= '0;
        end else if (i_sym_vld) begin
            m_cnt <= m_cnt + 1'b1;
        end
        for (int k = 0; k < N; k++) begin
            if (rst_m) begin
                m_chain[k]  <= '0;
                m_sgn[k]    <= '0;
                m_corr_i[k] <= 1'b0;
                m_corr_q[k] <= 1'b0;
                m_line_i[k] <= '0;
                m_line_q[k] <= '0;
            end else begin
                if (i_load) begin
                    m_chain[k] <= (k == 0) ? i_coedata : m_chain[k-1];
                end
                if (i_sym_vld) begin
                    m_sgn[k]    <= (k == 0) ? m_dly[SD-1] : m_sgn[k-1];
                    m_corr_i[k] <= m_sgn[k][0] ^ i_err_i;
                    m_corr_q[k] <= m_sgn[k][1] ^ i_err_q;
                end
                if (i_vldin && k > 0) begin
                    m_line_i[k] <= (k == 1) ? i_dtin_i : m_line_i[k-1];
                    m_line_q[k] <= (k == 1) ? i_dtin_q : m_line_q[k-1];
                end
            end
            if (rst_m || m_preset) begin
                m_acc_i[k] <= (k == CTR) ? FW'((1 << (FW - 3)) - 1) : '0;
                m_acc_q[k] <= '0;
                m_rnd_i[k] <= (k == CTR) ? CW'(UNIT_TOP) : '0;
                m_rnd_q[k] <= (k == CTR) ? CW'(UNIT_TOP) : '0;
                m_coe_i[k] <= (k == CTR) ? CW'(UNIT_TOP) : '0;
                m_coe_q[k] <= (k == CTR) ? CW'(UNIT_TOP) : '0;
            end else begin
                if (m_load) begin
                    m_acc_i[k] <= m_chain[k];
                    m_acc_q[k] <= '0;
                end else if (m_teach && i_sym_vld) begin
                    m_acc_i[k] <= adapt(m_acc_i[k], m_corr_i[k], m_norm);
                    m_acc_q[k] <= adapt(m_acc_q[k], m_corr_q[k], m_norm);
                end
                if (i_sym_vld) begin
                    m_rnd_i[k] <= round_coe(m_acc_i[k]);
                    m_rnd_q[k] <= round_coe(m_acc_q[k]);
                    m_coe_i[k] <= m_rnd_i[k];
                    m_coe_q[k] <= m_rnd_q[k];
                end
            end
        end
        for (int k = 0; k < SD; k++) begin
            if (rst_m) begin
                m_dly[k] <= '0;
            end else if (i_vldin) begin
                m_dly[k] <= (k == 0) ? {i_dtin_q[DW-1], i_dtin_i[DW-1]} : m_dly[k-1];
            end
        end
        exp_d1 <= exp_now;
        exp_d2 <= exp_d1;
        vld_d1 <= rst_m ? 1'b0 : i_vldin;
        vld_d2 <= rst_m ? 1'b0 : vld_d1;
    end

    // Convolution of the current window with the model taps
    always_comb begin
        longint s [4];
        logic signed [DW-1:0] di;
        logic signed [DW-1:0] dq;
        s = '{default: 0};
        for (int k = 0; k < N; k++) begin
            di = (k == 0) ? i_dtin_i : m_line_i[k];
            dq = (k == 0) ? i_dtin_q : m_line_q[k];
            s[0] += longint'(di) * longint'(m_coe_i[k]);
            s[1] += longint'(dq) * longint'(m_coe_q[k]);
            s[2] += longint'(di) * longint'(m_coe_q[k]);
            s[3] += longint'(dq) * longint'(m_coe_i[k]);
        end
        for (int j = 0; j < 4; j++) begin
            exp_now[j] = OW'(s[j]);
        end
    end

    a_vld : assert property (@(posedge clk) disable iff (rst_m) o_vld == vld_d2)
        else begin
            errors++;
            $display("MISMATCH t=%0t: o_vld is %0b, expected %0b", $time, o_vld, vld_d2);
        end

    a_ii : assert property (@(posedge clk) disable iff (rst_m) o_vld |-> o_dout_ii == exp_d2[0])
        else begin
            errors++;
            $display("MISMATCH t=%0t: II got %0d, expected %0d", $time, o_dout_ii, exp_d2[0]);
        end

    a_qq : assert property (@(posedge clk) disable iff (rst_m) o_vld |-> o_dout_qq == exp_d2[1])
        else begin
            errors++;
            $display("MISMATCH t=%0t: QQ got %0d, expected %0d", $time, o_dout_qq, exp_d2[1]);
        end

    a_iq : assert property (@(posedge clk) disable iff (rst_m) o_vld |-> o_dout_iq == exp_d2[2])
        else begin
            errors++;
            $display("MISMATCH t=%0t: IQ got %0d, expected %0d", $time, o_dout_iq, exp_d2[2]);
        end

    a_qi : assert property (@(posedge clk) disable iff (rst_m) o_vld |-> o_dout_qi == exp_d2[3])
        else begin
            errors++;
            $display("MISMATCH t=%0t: QI got %0d, expected %0d", $time, o_dout_qi, exp_d2[3]);
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    // One clock of stimulus with load and preset cleared
    task automatic drive_cycle(input logic vld, input logic sym, input logic ei,
                               input logic eq, input logic pos);
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = lcg_next();
        r2 = lcg_next();
        @(posedge clk);
        i_vldin   <= vld;
        i_sym_vld <= sym;
        i_err_i   <= ei;
        i_err_q   <= eq;
        i_load    <= 1'b0;
        i_preset  <= 1'b0;
        i_dtin_i  <= pos ? {1'b0, r1[30 -: DW-1]} : r1[31 -: DW];
        i_dtin_q  <= pos ? {1'b0, r2[30 -: DW-1]} : r2[31 -: DW];
    endtask

    // Random samples with symbols on about half the cycles
    task automatic run_random(input int n, input logic with_sym);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = lcg_next();
            drive_cycle(r[28] | r[27], with_sym & r[25], r[23], r[21], 1'b0);
        end
    endtask

    task automatic load_words(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = lcg_next();
            @(posedge clk);
            i_vldin   <= 1'b0;
            i_sym_vld <= 1'b0;
            i_load    <= 1'b1;
            i_coedata <= r[31 -: FW];
        end
    endtask

    initial begin
        clk           = 1'b0;
        sreset_eq     <= 1'b1;
        i_dtin_i      <= '0;
        i_dtin_q      <= '0;
        i_vldin       <= 1'b0;
        i_err_i       <= 1'b0;
        i_err_q       <= 1'b0;
        i_sym_vld     <= 1'b0;
        i_preset      <= 1'b0;
        i_load        <= 1'b0;
        i_teach_en    <= 1'b0;
        i_norm_period <= eq_pkg::NORM_PERIOD_RST;
        i_coedata     <= '0;
        repeat (10) @(posedge clk);
        sreset_eq <= 1'b0;
        repeat (3) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);

        // Unit centre-tap response after reset
        run_random(40, 1'b0);

        // Load the chain and copy it before two strobes move it to the FIR
        load_words(N);
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        run_random(40, 1'b0);

        // Teach off keeps the taps
        run_random(60, 1'b1);

        // Steady training with positive data and zero error
        i_teach_en    <= 1'b1;
        i_norm_period <= 10'd1023;
        for (int i = 0; i < 258; i++) begin
            drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
        end
        run_random(30, 1'b0);

        // Short leak period with random errors
        // The strobe counter first has to wrap past 1023
        i_norm_period <= 10'd5;
        run_random(2000, 1'b1);

        // Preset mid run
        @(posedge clk);
        i_teach_en <= 1'b0;
        i_preset   <= 1'b1;
        run_random(40, 1'b0);

        repeat (4) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        $display("Run complete: %0d cycles, %0d errors", cycles, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* lms_equalizer_top.sv */
`timescale 1ns/1ps

module lms_equalizer_top #(
    parameter int DATA_W  = eq_pkg::DEF_DATA_W,
    parameter int COE_W   = eq_pkg::DEF_COE_W,
    parameter int INV_W   = eq_pkg::DEF_INV_W,
    parameter int COE_NUM = eq_pkg::DEF_COE_NUM,
    parameter int SYM_DLY = eq_pkg::DEF_SYM_DLY
) (
    input  logic                                 clk,
    input  logic                                 sreset_eq,
    input  logic signed [DATA_W-1:0]             i_dtin_i,
    input  logic signed [DATA_W-1:0]             i_dtin_q,
    input  logic                                 i_vldin,
    input  logic                                 i_err_i,
    input  logic                                 i_err_q,
    input  logic                                 i_sym_vld,
    input  logic                                 i_preset,
    input  logic                                 i_load,
    input  logic                                 i_teach_en,
    input  logic [eq_pkg::NORM_PERIOD_W-1:0]     i_norm_period,
    input  logic signed [COE_W+INV_W-1:0]        i_coedata,
    output logic signed [DATA_W+COE_W+4:0]       o_dout_ii,
    output logic signed [DATA_W+COE_W+4:0]       o_dout_qq,
    output logic signed [DATA_W+COE_W+4:0]       o_dout_iq,
    output logic signed [DATA_W+COE_W+4:0]       o_dout_qi,
    output logic                                 o_vld
);

    logic                           rst_q;
    eq_pkg::eq_ctrl_t               ctrl_q;
    eq_pkg::eq_err_t                err;
    logic [COE_NUM-1:0]             corr_i;
    logic [COE_NUM-1:0]             corr_q;
    logic [COE_NUM*COE_W-1:0]       coe_i;
    logic [COE_NUM*COE_W-1:0]       coe_q;

    always_ff @(posedge clk) begin
        rst_q <= sreset_eq;
    end

    // Control pipe, reset leaves the taps at unit response
    always_ff @(posedge clk) begin
        if (rst_q) begin
            ctrl_q <= '{preset: 1'b1, load: 1'b0, teach_en: 1'b0,
                        norm_period: eq_pkg::NORM_PERIOD_RST};
        end else begin
            ctrl_q <= '{preset: i_preset, load: i_load, teach_en: i_teach_en,
                        norm_period: i_norm_period};
        end
    end

    assign err = '{sym_vld: i_sym_vld, err_i: i_err_i, err_q: i_err_q};

    eq_sign_corr #(
        .COE_NUM (COE_NUM),
        .SYM_DLY (SYM_DLY)
    ) u_sign_corr (
        .clk      (clk),
        .i_rst    (rst_q),
        .i_vldin  (i_vldin),
        .i_sign   ({i_dtin_q[DATA_W-1], i_dtin_i[DATA_W-1]}),
        .i_err    (err),
        .o_corr_i (corr_i),
        .o_corr_q (corr_q)
    );

    // Raw load feeds the chain, registered load copies it into the taps
    eq_coe_adapt #(
        .COE_W   (COE_W),
        .INV_W   (INV_W),
        .COE_NUM (COE_NUM)
    ) u_coe_adapt (
        .clk        (clk),
        .i_rst      (rst_q),
        .i_ctrl     (ctrl_q),
        .i_load_raw (i_load),
        .i_coedata  (i_coedata),
        .i_err      (err),
        .i_corr_i   (corr_i),
        .i_corr_q   (corr_q),
        .o_coe_i    (coe_i),
        .o_coe_q    (coe_q)
    );

    eq_fir #(.DATA_W(DATA_W), .COE_W(COE_W), .COE_NUM(COE_NUM)) u_fir_ii (
        .clk (clk), .i_rst (rst_q), .i_data (i_dtin_i), .i_vld (i_vldin),
        .i_coe (coe_i), .o_dout (o_dout_ii), .o_vld (o_vld)
    );

    // Remaining valids match II
    eq_fir #(.DATA_W(DATA_W), .COE_W(COE_W), .COE_NUM(COE_NUM)) u_fir_qq (
        .clk (clk), .i_rst (rst_q), .i_data (i_dtin_q), .i_vld (i_vldin),
        .i_coe (coe_q), .o_dout (o_dout_qq), .o_vld ()
    );

    eq_fir #(.DATA_W(DATA_W), .COE_W(COE_W), .COE_NUM(COE_NUM)) u_fir_iq (
        .clk (clk), .i_rst (rst_q), .i_data (i_dtin_i), .i_vld (i_vldin),
        .i_coe (coe_q), .o_dout (o_dout_iq), .o_vld ()
    );

    eq_fir #(.DATA_W(DATA_W), .COE_W(COE_W), .COE_NUM(COE_NUM)) u_fir_qi (
        .clk (clk), .i_rst (rst_q), .i_data (i_dtin_q), .i_vld (i_vldin),
        .i_coe (coe_i), .o_dout (o_dout_qi), .o_vld ()
    );

    a_preset_load_excl : assert property (
        @(posedge clk) disable iff (rst_q)
        !(i_preset && i_load)
    ) else $error("lms_equalizer_top: preset and load asserted together");

endmodule

/* eq_fir.sv */
`timescale 1ns/1ps

module eq_fir #(
    parameter int DATA_W  = eq_pkg::DEF_DATA_W,
    parameter int COE_W   = eq_pkg::DEF_COE_W,
    parameter int COE_NUM = eq_pkg::DEF_COE_NUM
) (
    input  logic                               clk,
    input  logic                               i_rst,
    input  logic signed [DATA_W-1:0]           i_data,
    input  logic                               i_vld,
    input  logic [COE_NUM*COE_W-1:0]           i_coe,
    output logic signed [DATA_W+COE_W+4:0]     o_dout,
    output logic                               o_vld
);

    localparam int PROD_W = DATA_W + COE_W;
    localparam int OUT_W  = DATA_W + COE_W + 5;

    logic [COE_NUM-1:0][COE_W-1:0]  coe;
    logic signed [DATA_W-1:0]       line_q [COE_NUM-1];
    logic signed [DATA_W-1:0]       tap [COE_NUM];
    logic signed [PROD_W-1:0]       prod_q [COE_NUM];
    logic signed [OUT_W-1:0]        sum;
    logic signed [OUT_W-1:0]        dout_q;
    logic [1:0]                     vld_q;

    assign coe = i_coe;

    // Window after the shift, tap 0 is the new sample
    always_comb begin
        tap[0] = i_data;
        for (int k = 1; k < COE_NUM; k++) begin
            tap[k] = line_q[k-1];
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int k = 0; k < COE_NUM - 1; k++) begin
                line_q[k] <= '0;
            end
        end else if (i_vld) begin
            line_q[0] <= i_data;
            for (int k = 1; k < COE_NUM - 1; k++) begin
                line_q[k] <= line_q[k-1];
            end
        end
    end

    // Stage 1
    always_ff @(posedge clk) begin
        if (i_vld) begin
            for (int k = 0; k < COE_NUM; k++) begin
                prod_q[k] <= tap[k] * $signed(coe[k]);
            end
        end
    end

    always_comb begin
        sum = '0;
        for (int k = 0; k < COE_NUM; k++) begin
            sum = sum + prod_q[k];
        end
    end

    // Stage 2
    always_ff @(posedge clk) begin
        if (vld_q[0]) begin
            dout_q <= sum;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[0], i_vld};
        end
    end

    assign o_dout = dout_q;
    assign o_vld  = vld_q[1];

    a_vld_latency : assert property (
        @(posedge clk) disable iff (i_rst)
        o_vld == $past(i_vld, 2)
    ) else $error("eq_fir: output valid is not the input strobe delayed by 2");

endmodule

/* eq_coe_adapt.sv */
`timescale 1ns/1ps

module eq_coe_adapt #(
    parameter int COE_W   = eq_pkg::DEF_COE_W,
    parameter int INV_W   = eq_pkg::DEF_INV_W,
    parameter int COE_NUM = eq_pkg::DEF_COE_NUM
) (
    input  logic                              clk,
    input  logic                              i_rst,
    input  eq_pkg::eq_ctrl_t                  i_ctrl,
    input  logic                              i_load_raw,
    input  logic signed [COE_W+INV_W-1:0]     i_coedata,
    input  eq_pkg::eq_err_t                   i_err,
    input  logic [COE_NUM-1:0]                i_corr_i,
    input  logic [COE_NUM-1:0]                i_corr_q,
    output logic [COE_NUM*COE_W-1:0]          o_coe_i,
    output logic [COE_NUM*COE_W-1:0]          o_coe_q
);

    localparam int FULL_W = COE_W + INV_W;
    localparam int CTR    = COE_NUM / 2;

    // Unit gain on the centre tap with three bits of headroom
    localparam logic signed [FULL_W-1:0] UNIT = FULL_W'((64'd1 << (FULL_W - 3)) - 64'd1);
    localparam logic [COE_W-1:0] UNIT_TOP = UNIT[FULL_W-1 -: COE_W];
    localparam logic [FULL_W:0]  HALF     = (FULL_W + 1)'(1) << (INV_W - 1);

    logic signed [FULL_W-1:0]             chain_q [COE_NUM];
    logic [eq_pkg::NORM_PERIOD_W-1:0]     norm_cnt_q;
    logic                                 norm_stb;
    logic signed [FULL_W-1:0]             acc_i_q [COE_NUM];
    logic signed [FULL_W-1:0]             acc_q_q [COE_NUM];
    logic [COE_W-1:0]                     rnd_i_q [COE_NUM];
    logic [COE_W-1:0]                     rnd_q_q [COE_NUM];
    logic [COE_NUM-1:0][COE_W-1:0]        coe_i_q;
    logic [COE_NUM-1:0][COE_W-1:0]        coe_q_q;

    // Leak toward zero or take a sign-sign training step
    function automatic logic signed [FULL_W-1:0] train_step(
        input logic signed [FULL_W-1:0] acc,
        input logic                     corr,
        input logic                     leak
    );
        if (leak) begin
            return acc[FULL_W-1] ? acc + 2'sd1 : acc - 2'sd1;
        end
        return corr ? acc - 2'sd1 : acc + 2'sd1;
    endfunction

    // Round half up to COE_W bits
    function automatic logic [COE_W-1:0] round_top(input logic signed [FULL_W-1:0] acc);
        logic [FULL_W:0] ext;
        ext = {acc[FULL_W-1], acc} + HALF;
        if (ext[FULL_W] != ext[FULL_W-1]) begin
            return {1'b0, {(COE_W-1){1'b1}}};
        end
        return ext[FULL_W-1 -: COE_W];
    endfunction

    // Serial load of the initial I taps
    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int k = 0; k < COE_NUM; k++) begin
                chain_q[k] <= '0;
            end
        end else if (i_load_raw) begin
            chain_q[0] <= i_coedata;
            for (int k = 1; k < COE_NUM; k++) begin
                chain_q[k] <= chain_q[k-1];
            end
        end
    end

    // Every (period+1)th symbol is a leakage step
    assign norm_stb = i_err.sym_vld && (norm_cnt_q == i_ctrl.norm_period);

    always_ff @(posedge clk) begin
        if (i_rst || norm_stb) begin
            norm_cnt_q <= '0;
        end else if (i_err.sym_vld) begin
            norm_cnt_q <= norm_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < COE_NUM; k++) begin
            if (i_rst || i_ctrl.preset) begin
                acc_i_q[k] <= (k == CTR) ? UNIT : '0;
                acc_q_q[k] <= '0;
            end else if (i_ctrl.load) begin
                acc_i_q[k] <= chain_q[k];
                acc_q_q[k] <= '0;
            end else if (i_ctrl.teach_en && i_err.sym_vld) begin
                acc_i_q[k] <= train_step(acc_i_q[k], i_corr_i[k], norm_stb);
                acc_q_q[k] <= train_step(acc_q_q[k], i_corr_q[k], norm_stb);
            end
        end
    end

    // Rounder stage starts from the coefficient preset
    // so the first strobe after preset keeps the taps
    always_ff @(posedge clk) begin
        for (int k = 0; k < COE_NUM; k++) begin
            if (i_rst || i_ctrl.preset) begin
                rnd_i_q[k] <= (k == CTR) ? UNIT_TOP : '0;
                rnd_q_q[k] <= (k == CTR) ? UNIT_TOP : '0;
                coe_i_q[k] <= (k == CTR) ? UNIT_TOP : '0;
                coe_q_q[k] <= (k == CTR) ? UNIT_TOP : '0;
            end else if (i_err.sym_vld) begin
                rnd_i_q[k] <= round_top(acc_i_q[k]);
                rnd_q_q[k] <= round_top(acc_q_q[k]);
                coe_i_q[k] <= rnd_i_q[k];
                coe_q_q[k] <= rnd_q_q[k];
            end
        end
    end

    assign o_coe_i = coe_i_q;
    assign o_coe_q = coe_q_q;

endmodule

/* eq_sign_corr.sv */
`timescale 1ns/1ps

module eq_sign_corr #(
    parameter int COE_NUM = eq_pkg::DEF_COE_NUM,
    parameter int SYM_DLY = eq_pkg::DEF_SYM_DLY
) (
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic                 i_vldin,
    input  logic [1:0]           i_sign,
    input  eq_pkg::eq_err_t      i_err,
    output logic [COE_NUM-1:0]   o_corr_i,
    output logic [COE_NUM-1:0]   o_corr_q
);

    // Bit 0 is the I rail, bit 1 the Q rail
    logic [SYM_DLY-1:0][1:0] dly_q;
    logic [COE_NUM-1:0][1:0] sgn_q;
    logic [COE_NUM-1:0]      corr_i_q;
    logic [COE_NUM-1:0]      corr_q_q;

    // Aligns the input sign with the decision latency of the slicer
    always_ff @(posedge clk) begin
        if (i_rst) begin
            dly_q <= '0;
        end else if (i_vldin) begin
            dly_q[0] <= i_sign;
            for (int k = 1; k < SYM_DLY; k++) begin
                dly_q[k] <= dly_q[k-1];
            end
        end
    end

    // One stored sign per tap, advanced at symbol rate
    always_ff @(posedge clk) begin
        if (i_rst) begin
            sgn_q <= '0;
        end else if (i_err.sym_vld) begin
            sgn_q[0] <= dly_q[SYM_DLY-1];
            for (int k = 1; k < COE_NUM; k++) begin
                sgn_q[k] <= sgn_q[k-1];
            end
        end
    end

    // Sign-sign correlation, 1 means the tap should step down
    always_ff @(posedge clk) begin
        if (i_rst) begin
            corr_i_q <= '0;
            corr_q_q <= '0;
        end else if (i_err.sym_vld) begin
            for (int k = 0; k < COE_NUM; k++) begin
                corr_i_q[k] <= sgn_q[k][0] ^ i_err.err_i;
                corr_q_q[k] <= sgn_q[k][1] ^ i_err.err_q;
            end
        end
    end

    assign o_corr_i = corr_i_q;
    assign o_corr_q = corr_q_q;

    // Training sees a steady correlation between symbol strobes
    a_corr_hold : assert property (
        @(posedge clk)
        (!i_rst && !i_err.sym_vld) |=> ($stable(o_corr_i) && $stable(o_corr_q))
    ) else $error("eq_sign_corr: correlation changed without a symbol strobe");

endmodule

/* eq_pkg.sv */
package eq_pkg;

    // Default sizes for the top level parameters
    localparam int DEF_DATA_W  = 16;
    localparam int DEF_COE_W   = 16;
    localparam int DEF_INV_W   = 8;
    localparam int DEF_COE_NUM = 19;
    localparam int DEF_SYM_DLY = 7;

    // Leakage period control
    localparam int NORM_PERIOD_W = 10;
    localparam logic [NORM_PERIOD_W-1:0] NORM_PERIOD_RST = 10'd4;

    // Registered control inputs
    typedef struct packed {
        logic                     preset;
        logic                     load;
        logic                     teach_en;
        logic [NORM_PERIOD_W-1:0] norm_period;
    } eq_ctrl_t;

    // Slicer error bits with their symbol strobe
    typedef struct packed {
        logic sym_vld;
        logic err_i;
        logic err_q;
    } eq_err_t;

endpackage
